//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= exStageTb
FILELIST  ?= verilog.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass is decided by the pass message in the output
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q -F '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

//--- hdl/aluUnit.sv
// ****************************************
// aluUnit
// Adder/comparator ALU. Add, subtract,
// signed and unsigned compares from one
// extended subtraction, and conditional
// move steered by the registered flag
// ****************************************

`timescale 1ns/1ps

module aluUnit
  import exPkg::*;
(
  input  aluReqS req,        // Opcode and operands from decode
  input  logic   flag,       // Registered flag, steers CMOV
  output dataT   result,     // Sum or CMOV pick
  output logic   cmpResult,  // Compare condition met
  output logic   isCompare   // Opcode is one of the compares
);

  logic [dataWidth:0] aExt;      // One extra bit on top
  logic [dataWidth:0] bExt;
  logic [dataWidth:0] bSel;      // B or its inverse
  logic [dataWidth:0] sum;
  logic               isSub;
  logic               isCmov;
  logic               isZero;    // A equals B
  logic               lessThan;  // Borrow bit

  // ****************************************
  // Operand extension and adder
  // ****************************************
  // Zero extension for unsigned opcodes, sign extension otherwise
  assign aExt = req.op[3] ? {1'b0, req.a} : {req.a[dataWidth-1], req.a};
  assign bExt = req.op[3] ? {1'b0, req.b} : {req.b[dataWidth-1], req.b};

  // Everything but add subtracts
  assign isSub  = (req.op != opAdd);
  assign isCmov = (req.op == opCmov);
  assign bSel   = isSub ? ~bExt : bExt;
  assign sum    = aExt + bSel + (dataWidth+1)'(isSub);  // Carry-in completes two's complement

  // Compares sit at low codes 010 to 111
  assign isCompare = (req.op[2:1] != 2'b00);

  // ****************************************
  // Compare evaluation
  // ****************************************
  assign isZero   = ~|sum[dataWidth-1:0];
  assign lessThan = sum[dataWidth];         // Top bit of A minus B

  always_comb
  begin
    case (req.op[2:0])
      3'b010:  cmpResult = isZero;                 // EQ
      3'b011:  cmpResult = ~isZero;                // NEQ
      3'b100:  cmpResult = lessThan | isZero;      // LE
      3'b101:  cmpResult = lessThan;               // LT
      3'b110:  cmpResult = ~lessThan;              // GE
      3'b111:  cmpResult = ~lessThan & ~isZero;    // GT
      default: cmpResult = 1'b0;                   // Add, sub, cmov
    endcase
  end

  // ****************************************
  // Result select
  // ****************************************
  always_comb
  begin
    if (isCmov)
      result = flag ? req.a : req.b;   // Flag from an earlier compare
    else
      result = sum[dataWidth-1:0];     // Low word only
  end

endmodule

//--- hdl/exPkg.sv
// ****************************************
// exPkg
// Widths, opcodes and port bundles shared
// by the execution stage and its units
// ****************************************

package exPkg;

  // ****************************************
  // Widths fixed by the ISA
  // ****************************************
  localparam int dataWidth    = 32;                 // One data word
  localparam int rfIndexWidth = 5;                  // 32-entry register file
  localparam int shamtWidth   = $clog2(dataWidth);  // Shift amount bits

  typedef logic [dataWidth-1:0]    dataT;
  typedef logic [rfIndexWidth-1:0] rfAddrT;

  // ALU opcodes, bit 3 selects zero extension
  typedef enum logic [3:0] {
    opAdd  = 4'b0000,
    opSub  = 4'b0001,
    opCmov = 4'b1000,   // A if flag else B
    opEq   = 4'b0010,
    opNeq  = 4'b0011,
    opLe   = 4'b0100,
    opLt   = 4'b0101,
    opGe   = 4'b0110,
    opGt   = 4'b0111,
    opEqU  = 4'b1010,   // Unsigned compares
    opNeqU = 4'b1011,
    opLeU  = 4'b1100,
    opLtU  = 4'b1101,
    opGeU  = 4'b1110,
    opGtU  = 4'b1111
  } aluOpE;

  // Multiply/shift/logic opcodes, code 7 falls back to AND
  typedef enum logic [2:0] {
    mslMul = 3'b000,    // Low word of product
    mslOr  = 3'b001,
    mslAnd = 3'b010,
    mslXor = 3'b011,
    mslSll = 3'b100,
    mslSrl = 3'b101,
    mslSra = 3'b110     // Sign fill from A
  } mslOpE;

  // Write-back source, code 3 falls back to the ALU
  typedef enum logic [1:0] {
    wbAlu = 2'b00,
    wbLsu = 2'b01,      // Load data
    wbMsl = 2'b10
  } wbSelE;

  // ****************************************
  // Port bundles
  // ****************************************
  typedef struct packed {aluOpE op; dataT a; dataT b;} aluReqS;
  typedef struct packed {mslOpE op; dataT a; dataT b;} mslReqS;
  typedef struct packed {logic updFlag; logic updP0; logic updP1;} predUpdS;
  typedef struct packed {logic rfWe; wbSelE sel; rfAddrT addr;} wbCtrlS;
  typedef struct packed {logic we; rfAddrT addr; dataT data;} wbOutS;
  typedef struct packed {dataT alu; dataT msl; dataT shadow;} bypassS;

endpackage

//--- hdl/exStage.sv
// ****************************************
// exStage
// Execution stage of the 32-bit RISC PE.
// ALU with predicate registers, multiply/
// shift/logic unit and write-back select,
// plus bypass paths back to decode
// ****************************************

`timescale 1ns/1ps

module exStage
  import exPkg::*;
(
  input  logic    iClk,
  input  logic    rstN,

  // From decode
  input  aluReqS  aluReq,
  input  mslReqS  mslReq,
  input  predUpdS predUpd,
  input  wbCtrlS  wbCtrl,
  input  logic    writeShadow,   // Write R31

  // From data memory
  input  dataT    dmemData,

  // To decode
  output logic    p0,
  output logic    p1,
  output bypassS  bypass,

  // To write-back
  output wbOutS   wb
);

  dataT aluResult;
  dataT mslResult;
  dataT shadow;      // R31 contents
  logic cmpResult;
  logic isCompare;
  logic flag;        // Registered, feeds CMOV

  // ****************************************
  // ALU and predicates
  // ****************************************
  aluUnit alu0 (
    .req       (aluReq),
    .flag      (flag),
    .result    (aluResult),
    .cmpResult (cmpResult),
    .isCompare (isCompare)
  );

  predicateRegs pred0 (
    .iClk      (iClk),
    .rstN      (rstN),
    .upd       (predUpd),
    .isCompare (isCompare),
    .cmpResult (cmpResult),
    .flag      (flag),
    .p0        (p0),
    .p1        (p1)
  );

  // Multiply, shift and logic
  mulShiftLogic msl0 (
    .req    (mslReq),
    .result (mslResult)
  );

  // ****************************************
  // Write-back and shadow register
  // ****************************************
  writebackSelect wbSel0 (
    .iClk        (iClk),
    .rstN        (rstN),
    .ctrl        (wbCtrl),
    .aluResult   (aluResult),
    .mslResult   (mslResult),
    .dmemData    (dmemData),
    .writeShadow (writeShadow),
    .wb          (wb),
    .shadow      (shadow)
  );

  assign bypass = '{alu: aluResult, msl: mslResult, shadow: shadow};   // Bypass bundle

endmodule

//--- hdl/mulShiftLogic.sv
// ****************************************
// mulShiftLogic
// Multiply (low word), bitwise logic and
// logical or arithmetic shifts by the low
// bits of operand B
// ****************************************

`timescale 1ns/1ps

module mulShiftLogic
  import exPkg::*;
(
  input  mslReqS req,     // Opcode and operands from decode
  output dataT   result
);

  logic [shamtWidth-1:0] shamt;      // Shift amount
  dataT                  product;    // Low word of A times B
  dataT                  shiftLeft;
  dataT                  shiftRight; // Zero fill
  dataT                  shiftArith; // Sign fill

  assign shamt = req.b[shamtWidth-1:0];   // Upper bits of B ignored

  // ****************************************
  // Datapath pieces
  // ****************************************
  // Product truncated to one word by the target width
  assign product = req.a * req.b;

  assign shiftLeft  = req.a << shamt;
  assign shiftRight = req.a >> shamt;
  assign shiftArith = $signed(req.a) >>> shamt;   // Fills with A[31]

  // ****************************************
  // Result select
  // ****************************************
  always_comb
  begin
    case (req.op)
      mslMul:
        result = product;
      mslOr:
        result = req.a | req.b;
      mslAnd:
        result = req.a & req.b;
      mslXor:
        result = req.a ^ req.b;
      mslSll:
        result = shiftLeft;
      mslSrl:
        result = shiftRight;
      mslSra:
        result = shiftArith;
      default:
        result = req.a & req.b;   // Unused code acts as AND
    endcase
  end

endmodule

//--- hdl/predicateRegs.sv
// ****************************************
// predicateRegs
// Flag, P0 and P1 predicate registers,
// loaded by compares. P0 and P1 forward
// the new value to decode in the same cycle
// ****************************************

`timescale 1ns/1ps

module predicateRegs
  import exPkg::*;
(
  input  logic    iClk,
  input  logic    rstN,
  input  predUpdS upd,        // Per-register update bits
  input  logic    isCompare,
  input  logic    cmpResult,
  output logic    flag,       // Registered value only
  output logic    p0,         // Forwarded
  output logic    p1          // Forwarded
);

  logic flagQ;
  logic p0Q;
  logic p1Q;
  logic flagWe;
  logic p0We;
  logic p1We;

  // Writes only happen on compares
  assign flagWe = isCompare & upd.updFlag;
  assign p0We   = isCompare & upd.updP0;
  assign p1We   = isCompare & upd.updP1;

  always_ff @(posedge iClk)
  begin
    if (!rstN)
    begin
      flagQ <= 1'b0;
      p0Q   <= 1'b0;
      p1Q   <= 1'b0;
    end
    else
    begin
      if (flagWe) flagQ <= cmpResult;
      if (p0We)   p0Q   <= cmpResult;
      if (p1We)   p1Q   <= cmpResult;
    end
  end

  // Decode sees the compare outcome without waiting a cycle
  assign p0   = p0We ? cmpResult : p0Q;
  assign p1   = p1We ? cmpResult : p1Q;
  assign flag = flagQ;   // CMOV uses the earlier value

endmodule

//--- hdl/writebackSelect.sv
// ****************************************
// writebackSelect
// Picks the stage result for write-back
// and holds the shadow register R31
// ****************************************

`timescale 1ns/1ps

module writebackSelect
  import exPkg::*;
(
  input  logic   iClk,
  input  logic   rstN,
  input  wbCtrlS ctrl,         // Enable, source and index
  input  dataT   aluResult,
  input  dataT   mslResult,
  input  dataT   dmemData,     // Load data from memory
  input  logic   writeShadow,  // Load R31 this cycle
  output wbOutS  wb,
  output dataT   shadow
);

  dataT stageResult;
  dataT shadowQ;

  // Source select, spare code goes to the ALU
  always_comb
  begin
    case (ctrl.sel)
      wbAlu:   stageResult = aluResult;
      wbLsu:   stageResult = dmemData;
      wbMsl:   stageResult = mslResult;
      default: stageResult = aluResult;
    endcase
  end

  // Shadow register R31
  always_ff @(posedge iClk)
  begin
    if (!rstN)
      shadowQ <= '0;
    else if (writeShadow)
      shadowQ <= stageResult;   // Visible from the next cycle
  end

  // Enable and index ride along with the data unchanged
  assign wb.we   = ctrl.rfWe;
  assign wb.addr = ctrl.addr;
  assign wb.data = stageResult;
  assign shadow  = shadowQ;

endmodule

//--- testbench/exStageTb.sv
// ****************************************
// exStageTb
// Testbench for the execution stage.
// Directed corner cases then random
// cycles, checked against a model
// ****************************************

`timescale 1ns/1ps

module exStageTb
  import exPkg::*;
();

  localparam int resetCycles    = 16;
  localparam int directedCycles = 24;
  localparam int randomCycles   = 2000;
  localparam int totalCycles    = resetCycles + directedCycles + randomCycles + 8;

  // Model state mirroring the stage registers
  typedef struct packed {logic flag; logic p0; logic p1; dataT shadow;} modelS;
  typedef struct packed {logic p0; logic p1; bypassS bypass; wbOutS wb; modelS next;} refS;

  logic    iClk;
  logic    rstN;
  aluReqS  aluReq;
  mslReqS  mslReq;
  predUpdS predUpd;
  wbCtrlS  wbCtrl;
  logic    writeShadow;
  dataT    dmemData;
  logic    p0;
  logic    p1;
  bypassS  bypass;
  wbOutS   wb;

  modelS   model;
  int      errorCount;
  aluOpE   aluOps [15];   // Legal ALU opcodes for random picks

  exStage dut0 (.*);

  initial
  begin
    iClk = 1'b0;
    forever #2 iClk = ~iClk;
  end

  // ****************************************
  // Reference model from the stage rules
  // ****************************************
  function automatic refS computeExpected(aluReqS ar, mslReqS mr, predUpdS pu, wbCtrlS wc,
                                          logic ws, dataT dm, modelS st);
    refS  r;
    logic isCmp;
    logic cond;
    dataT aluV;
    dataT mslV;
    dataT wbV;
    logic [shamtWidth-1:0] sh;
    isCmp = 1'b1;
    cond  = 1'b0;
    aluV  = ar.a - ar.b;              // Compares leave the difference
    case (ar.op)
      opAdd:
      begin
        aluV  = ar.a + ar.b;
        isCmp = 1'b0;
      end
      opSub:         isCmp = 1'b0;
      opCmov:
      begin
        aluV  = st.flag ? ar.a : ar.b;
        isCmp = 1'b0;
      end
      opEq, opEqU:   cond = (ar.a == ar.b);
      opNeq, opNeqU: cond = (ar.a != ar.b);
      opLe:          cond = ($signed(ar.a) <= $signed(ar.b));
      opLt:          cond = ($signed(ar.a) < $signed(ar.b));
      opGe:          cond = ($signed(ar.a) >= $signed(ar.b));
      opGt:          cond = ($signed(ar.a) > $signed(ar.b));
      opLeU:         cond = (ar.a <= ar.b);
      opLtU:         cond = (ar.a < ar.b);
      opGeU:         cond = (ar.a >= ar.b);
      opGtU:         cond = (ar.a > ar.b);
      default:       isCmp = 1'b0;
    endcase
    sh = mr.b[shamtWidth-1:0];
    case (mr.op)
      mslMul:  mslV = mr.a * mr.b;
      mslOr:   mslV = mr.a | mr.b;
      mslXor:  mslV = mr.a ^ mr.b;
      mslSll:  mslV = mr.a << sh;
      mslSrl:  mslV = mr.a >> sh;
      mslSra:  mslV = $signed(mr.a) >>> sh;
      default: mslV = mr.a & mr.b;    // AND and the spare code
    endcase
    case (wc.sel)
      wbLsu:   wbV = dm;
      wbMsl:   wbV = mslV;
      default: wbV = aluV;
    endcase
    r.p0          = (isCmp && pu.updP0) ? cond : st.p0;   // Forwarded same cycle
    r.p1          = (isCmp && pu.updP1) ? cond : st.p1;
    r.bypass      = '{alu: aluV, msl: mslV, shadow: st.shadow};
    r.wb          = '{we: wc.rfWe, addr: wc.addr, data: wbV};
    r.next.flag   = (isCmp && pu.updFlag) ? cond : st.flag;
    r.next.p0     = r.p0;
    r.next.p1     = r.p1;
    r.next.shadow = ws ? wbV : st.shadow;
    return r;
  endfunction

  // ****************************************
  // Compare tasks
  // ****************************************
  task automatic checkData(input string name, input dataT expV, input dataT actV);
    if (actV !== expV)
    begin
      errorCount++;
      $display("[FAIL] %0t %s expected %h got %h", $time, name, expV, actV);
      $display("*** TEST FAILED ***");
      $fatal(1, "Data mismatch");
    end
  endtask

  task automatic checkBit(input string name, input logic expV, input logic actV);
    if (actV !== expV)
    begin
      errorCount++;
      $display("[FAIL] %0t %s expected %b got %b", $time, name, expV, actV);
      $display("*** TEST FAILED ***");
      $fatal(1, "Bit mismatch");
    end
  endtask

  task automatic checkWb(input string name, input wbOutS expV, input wbOutS actV);
    if (actV !== expV)
    begin
      errorCount++;
      $display("[FAIL] %0t %s expected we=%b addr=%0d data=%h got we=%b addr=%0d data=%h",
               $time, name, expV.we, expV.addr, expV.data, actV.we, actV.addr, actV.data);
      $display("*** TEST FAILED ***");
      $fatal(1, "Write-back mismatch");
    end
  endtask

  // Sample on the falling edge where outputs are stable
  initial
  begin
    refS r;
    forever
    begin
      @(negedge iClk);
      if (rstN !== 1'b1)
        model = '0;
      else
      begin
        r = computeExpected(aluReq, mslReq, predUpd, wbCtrl, writeShadow, dmemData, model);
        checkBit("p0", r.p0, p0);
        checkBit("p1", r.p1, p1);
        checkData("bypass.alu", r.bypass.alu, bypass.alu);
        checkData("bypass.msl", r.bypass.msl, bypass.msl);
        checkData("bypass.shadow", r.bypass.shadow, bypass.shadow);
        checkWb("wb", r.wb, wb);
        model = r.next;   // Registers take this at the next edge
      end
    end
  end

  // ****************************************
  // Stimulus
  // ****************************************
  task automatic driveCycle(input aluReqS ar, input mslReqS mr, input predUpdS pu,
                            input wbCtrlS wc, input logic ws, input dataT dm);
    @(posedge iClk);
    aluReq      <= ar;
    mslReq      <= mr;
    predUpd     <= pu;
    wbCtrl      <= wc;
    writeShadow <= ws;
    dmemData    <= dm;
  endtask

  task automatic randomCycle();
    aluReqS     ar;
    mslReqS     mr;
    wbCtrlS     wc;
    logic [2:0] mop;
    logic [1:0] sel;
    ar.op = aluOps[4'($urandom_range(0, 14))];
    ar.a  = $urandom;
    ar.b  = ($urandom_range(0, 7) == 0) ? ar.a : $urandom;   // Some equal pairs
    mop   = 3'($urandom_range(0, 7));
    mr.op = mslOpE'(mop);
    mr.a  = $urandom;
    mr.b  = $urandom;
    sel   = 2'($urandom_range(0, 3));
    wc.sel  = wbSelE'(sel);
    wc.rfWe = 1'($urandom_range(0, 1));
    wc.addr = 5'($urandom_range(0, 31));
    driveCycle(ar, mr, predUpdS'(3'($urandom_range(0, 7))), wc,
               1'($urandom_range(0, 1)), $urandom);
  endtask

  task automatic directedCases();
    predUpdS all;
    predUpdS none;
    all  = '{updFlag: 1'b1, updP0: 1'b1, updP1: 1'b1};
    none = '0;
    driveCycle('{opAdd, 32'd7, 32'd5}, '{mslAnd, 32'hff, 32'h0f}, none,
               '{1'b0, wbAlu, 5'd1}, 1'b0, 32'h0);
    driveCycle('{opSub, 32'd3, 32'd9}, '{mslOr, 32'h1, 32'h2}, none,
               '{1'b1, wbAlu, 5'd2}, 1'b0, 32'h0);
    // Equal operands
    driveCycle('{opEq, 32'h1234, 32'h1234}, '{mslXor, 32'hf0, 32'hff}, all,
               '{1'b1, wbAlu, 5'd3}, 1'b0, 32'h0);
    driveCycle('{opCmov, 32'haaaa, 32'hbbbb}, '{mslMul, 32'd6, 32'd7}, none,
               '{1'b1, wbAlu, 5'd4}, 1'b0, 32'h0);
    driveCycle('{opGeU, 32'h5, 32'h5}, '{mslMul, 32'hffffffff, 32'd3}, all,
               '{1'b1, wbMsl, 5'd5}, 1'b0, 32'h0);
    // Sign boundary where signed and unsigned disagree
    driveCycle('{opLt, 32'h80000000, 32'h7fffffff}, '{mslSra, 32'h80000001, 32'd0},
               '{updFlag: 1'b1, updP0: 1'b1, updP1: 1'b0}, '{1'b1, wbMsl, 5'd6}, 1'b0, 32'h0);
    driveCycle('{opCmov, 32'h11, 32'h22}, '{mslSra, 32'h80000001, 32'd31}, none,
               '{1'b1, wbMsl, 5'd7}, 1'b1, 32'h0);
    driveCycle('{opLtU, 32'h80000000, 32'h7fffffff}, '{mslSrl, 32'h80000001, 32'd31},
               '{updFlag: 1'b1, updP0: 1'b0, updP1: 1'b1}, '{1'b0, wbAlu, 5'd8}, 1'b0, 32'h0);
    driveCycle('{opCmov, 32'h11, 32'h22}, '{mslSll, 32'h80000001, 32'd31}, none,
               '{1'b1, wbAlu, 5'd9}, 1'b0, 32'h0);
    driveCycle('{opGt, 32'hffffffff, 32'h0}, '{mslSll, 32'h3, 32'hffffffe0}, all,
               '{1'b1, wbLsu, 5'd10}, 1'b1, 32'hdeadbeef);
    driveCycle('{opLe, 32'h0, 32'h0}, '{mslOpE'(3'd7), 32'hf0f0, 32'hff00}, none,
               '{1'b1, wbMsl, 5'd11}, 1'b1, 32'h0);
    driveCycle('{opNeqU, 32'h1, 32'h2}, '{mslSrl, 32'h12345678, 32'd0}, all,
               '{1'b0, wbAlu, 5'd12}, 1'b0, 32'h0);
  endtask

  // Watchdog sized from the cycle budget
  initial
  begin
    #(totalCycles * 4 + 1000);
    $display("Run hung, watchdog expired before the tests finished");
    $display("*** TEST FAILED ***");
    $fatal(1, "Timeout");
  end

  initial
  begin
    void'($urandom(32'hf6a1aba2));
    errorCount  = 0;
    model       = '0;
    rstN        = 1'b0;
    aluReq      = '{opAdd, 32'h0, 32'h0};
    mslReq      = '{mslAnd, 32'h0, 32'h0};
    predUpd     = '0;
    wbCtrl      = '{1'b0, wbAlu, 5'd0};
    writeShadow = 1'b0;
    dmemData    = '0;
    aluOps      = '{opAdd, opSub, opCmov, opEq, opNeq, opLe, opLt, opGe, opGt,
                    opEqU, opNeqU, opLeU, opLtU, opGeU, opGtU};
    repeat (resetCycles) @(posedge iClk);
    rstN <= 1'b1;
    directedCases();
    repeat (randomCycles) randomCycle();
    repeat (3) @(posedge iClk);
    if (errorCount == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- testbench/exStage_assert.sv
// ****************************************
// exStageChecks
// Register update rules of the stage,
// bound into exStage
// ****************************************

`timescale 1ns/1ps

module exStageChecks
  import exPkg::*;
(
  input logic    iClk,
  input logic    rstN,
  input predUpdS predUpd,
  input logic    isCompare,
  input logic    flag,
  input logic    writeShadow,
  input dataT    shadow,
  input wbOutS   wb
);

  // Flag moves only after a compare that updates it
  flagHold: assert property (@(posedge iClk) disable iff (!rstN)
    !(isCompare && predUpd.updFlag) |=> $stable(flag))
    else $error("flag changed without a flag-updating compare");

  // R31 moves only after writeShadow
  shadowHold: assert property (@(posedge iClk) disable iff (!rstN)
    !writeShadow |=> $stable(shadow))
    else $error("shadow changed without writeShadow");

  // R31 holds the write-back data of the writing cycle
  shadowLoad: assert property (@(posedge iClk) disable iff (!rstN)
    writeShadow |=> (shadow == $past(wb.data)))
    else $error("shadow did not capture the write-back data");

endmodule

bind exStage exStageChecks chk0 (.*);

//--- verilog.f
hdl/exPkg.sv
hdl/aluUnit.sv
hdl/predicateRegs.sv
hdl/mulShiftLogic.sv
hdl/writebackSelect.sv
hdl/exStage.sv
testbench/exStage_assert.sv
testbench/exStageTb.sv
